// File: rv_core.f
rv_core_pkg.sv
rv_fetch.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_lsu.sv
rv_core.sv
rv_core_properties.sv
tb_rv_core.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_rv_core
FILELIST = rv_core.f
LOG      = sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(EXE): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(EXE)
	./$(EXE) | tee $(LOG)
	grep -qx "Simulation passed" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import rv_core_pkg::*; ();

  logic            clk;
  logic            rst_n;
  logic            imem_ren;
  logic [xlen-1:0] imem_raddr;
  logic [31:0]     imem_rdata;
  logic            dmem_ren;
  logic [xlen-1:0] dmem_raddr;
  logic [xlen-1:0] dmem_rdata;
  logic            dmem_we;
  logic [xlen-1:0] dmem_waddr;
  logic [xlen-1:0] dmem_wdata;
  logic [3:0]      dmem_wstrb;
  logic            ebreak;

  logic [31:0]     irom [0:255];
  logic [xlen-1:0] dram [0:255];

  // Expected store table and the entry the next store must match
  logic [xlen-1:0] exp_addr [0:127];
  logic [3:0]      exp_strb [0:127];
  logic [xlen-1:0] exp_data [0:127];
  logic [xlen-1:0] cur_addr;
  logic [3:0]      cur_strb;
  logic [xlen-1:0] cur_data;
  int              n_exp = 0;
  int              store_idx = 0;
  int              errors = 0;

  string           test_name [0:7];
  int              test_last [0:7];
  int              n_tests = 0;
  int              test_idx = 0;
  int              err_mark = 0;
  int              tests_pass = 0;
  int              tests_fail = 0;

  // Program assembly state; a and b are the values placed in x1 and x2
  int              pc_w = 0;
  int              mb = 32'h100;
  logic [xlen-1:0] a;
  logic [xlen-1:0] b;

  always #20 clk = ~clk;

  rv_core u_rv_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .ebreak     (ebreak)
  );

  // ------------------------------
  // Memory models
  // ------------------------------
  assign imem_rdata = irom[imem_raddr[9:2]];

  // Read data is only valid while the read enable is high
  assign dmem_rdata = dmem_ren ? dram[dmem_raddr[9:2]] : 32'hDEAD_BEEF;

  always @(posedge clk) begin
    if (dmem_we) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_wstrb[i]) begin
          dram[dmem_waddr[9:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
        end
      end
    end
  end

  // ------------------------------
  // Instruction encoders
  // ------------------------------
  function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                         input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_op};
  endfunction

  function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
                                         input int rd, input opcode_e opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                         input logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] b_type(input int imm, input int rs1, input int rs2,
                                         input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic logic [31:0] u_type(input int imm, input int rd, input opcode_e opc);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
  endfunction

  // RV32I branch conditions
  function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                      input logic [31:0] y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  function automatic logic [31:0] reg_value(input int r);
    return (r == 1) ? a : b;
  endfunction

  // ------------------------------
  // Program builder
  // ------------------------------
  task automatic emit(input logic [31:0] instr);
    irom[pc_w[7:0]] = instr;
    pc_w++;
  endtask

  task automatic add_store(input logic [31:0] addr, input logic [3:0] strb,
                           input logic [31:0] data);
    exp_addr[n_exp[6:0]] = addr;
    exp_strb[n_exp[6:0]] = strb;
    exp_data[n_exp[6:0]] = data;
    n_exp++;
  endtask

  // sw x3 to the next mailbox word
  task automatic store_result(input logic [31:0] value);
    emit(s_type(mb, 3, 0, 3'b010));
    add_store(mb, 4'hF, value);
    mb += 4;
  endtask

  task automatic result_case(input logic [31:0] instr, input logic [31:0] value);
    emit(instr);
    store_result(value);
  endtask

  task automatic end_test(input string name);
    test_name[n_tests[2:0]] = name;
    test_last[n_tests[2:0]] = n_exp - 1;
    n_tests++;
  endtask

  task automatic build_program();
    int f3s [0:5] = '{0, 1, 4, 5, 6, 7};
    int ra [0:2] = '{1, 2, 1};
    int rb [0:2] = '{2, 1, 1};
    int link_pc;
    emit(u_type(32'h87654, 1, opc_lui));
    emit(i_type(32'h321, 1, 3'b000, 1, opc_op_imm));
    emit(i_type(-123, 0, 3'b000, 2, opc_op_imm));
    // Register and immediate ALU forms, result in x3
    result_case(r_type(7'h00, 2, 1, 3'b000, 3), a + b);
    result_case(r_type(7'h20, 2, 1, 3'b000, 3), a - b);
    result_case(r_type(7'h00, 2, 1, 3'b001, 3), a << b[4:0]);
    result_case(r_type(7'h00, 2, 1, 3'b010, 3), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    result_case(r_type(7'h00, 1, 2, 3'b011, 3), (b < a) ? 32'd1 : 32'd0);
    result_case(r_type(7'h00, 2, 1, 3'b100, 3), a ^ b);
    result_case(r_type(7'h00, 2, 1, 3'b101, 3), a >> b[4:0]);
    result_case(r_type(7'h20, 2, 1, 3'b101, 3),
                (a >> b[4:0]) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> b[4:0])));
    result_case(r_type(7'h00, 2, 1, 3'b110, 3), a | b);
    result_case(r_type(7'h00, 2, 1, 3'b111, 3), a & b);
    result_case(i_type(-2048, 1, 3'b000, 3, opc_op_imm), a + 32'hFFFF_F800);
    result_case(i_type(-1, 1, 3'b010, 3, opc_op_imm), ($signed(a) < -1) ? 32'd1 : 32'd0);
    result_case(i_type(-1, 1, 3'b011, 3, opc_op_imm), (a < 32'hFFFF_FFFF) ? 32'd1 : 32'd0);
    result_case(i_type(32'h7F0, 1, 3'b100, 3, opc_op_imm), a ^ 32'h7F0);
    result_case(i_type(-16, 1, 3'b110, 3, opc_op_imm), a | 32'hFFFF_FFF0);
    result_case(i_type(32'h0FF, 1, 3'b111, 3, opc_op_imm), a & 32'h0FF);
    result_case(i_type(4, 1, 3'b001, 3, opc_op_imm), a << 4);
    result_case(i_type(28, 1, 3'b101, 3, opc_op_imm), a >> 28);
    result_case(i_type(32'h41C, 1, 3'b101, 3, opc_op_imm),
                (a >> 28) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> 28)));
    result_case(u_type(32'hABCDE, 3, opc_lui), 32'hABCD_E000);
    result_case(u_type(32'h12345, 3, opc_auipc), 32'(pc_w * 4) + 32'h1234_5000);
    end_test("alu");
    // Every byte lane, both half lanes and a full word
    emit(s_type(32'h80, 1, 0, 3'b000));
    add_store(32'h80, 4'b0001, {4{a[7:0]}});
    emit(s_type(32'h81, 2, 0, 3'b000));
    add_store(32'h80, 4'b0010, {4{b[7:0]}});
    emit(s_type(32'h82, 1, 0, 3'b000));
    add_store(32'h80, 4'b0100, {4{a[7:0]}});
    emit(s_type(32'h83, 2, 0, 3'b000));
    add_store(32'h80, 4'b1000, {4{b[7:0]}});
    emit(s_type(32'h84, 1, 0, 3'b001));
    add_store(32'h84, 4'b0011, {2{a[15:0]}});
    emit(s_type(32'h86, 2, 0, 3'b001));
    add_store(32'h84, 4'b1100, {2{b[15:0]}});
    emit(s_type(32'h88, 1, 0, 3'b010));
    add_store(32'h88, 4'b1111, a);
    end_test("store sizes");
    result_case(i_type(32'h81, 0, 3'b000, 3, opc_load), {{24{b[7]}}, b[7:0]});
    result_case(i_type(32'h81, 0, 3'b100, 3, opc_load), {24'h0, b[7:0]});
    result_case(i_type(32'h82, 0, 3'b000, 3, opc_load), {{24{a[7]}}, a[7:0]});
    result_case(i_type(32'h83, 0, 3'b100, 3, opc_load), {24'h0, b[7:0]});
    result_case(i_type(32'h84, 0, 3'b001, 3, opc_load), {{16{a[15]}}, a[15:0]});
    result_case(i_type(32'h84, 0, 3'b101, 3, opc_load), {16'h0, a[15:0]});
    result_case(i_type(32'h86, 0, 3'b001, 3, opc_load), {{16{b[15]}}, b[15:0]});
    result_case(i_type(32'h86, 0, 3'b101, 3, opc_load), {16'h0, b[15:0]});
    result_case(i_type(32'h88, 0, 3'b010, 3, opc_load), a);
    end_test("load extension");
    // x3 ends as 1 only when the branch falls through
    for (int i = 0; i < 6; i++) begin
      for (int j = 0; j < 3; j++) begin
        emit(i_type(0, 0, 3'b000, 3, opc_op_imm));
        emit(b_type(8, ra[j], rb[j], f3s[i][2:0]));
        emit(i_type(1, 0, 3'b000, 3, opc_op_imm));
        store_result(branch_taken(f3s[i][2:0], reg_value(ra[j]), reg_value(rb[j])) ?
                     32'd0 : 32'd1);
      end
    end
    end_test("branches");
    // A skipped marker store would land out of order in the table
    link_pc = pc_w * 4;
    emit(j_type(8, 7));
    emit(s_type(mb, 1, 0, 3'b010));
    emit(s_type(mb, 7, 0, 3'b010));
    add_store(mb, 4'hF, link_pc + 4);
    mb += 4;
    link_pc = pc_w * 4;
    emit(u_type(0, 8, opc_auipc));
    emit(i_type(13, 8, 3'b000, 9, opc_jalr));
    emit(s_type(mb, 1, 0, 3'b010));
    emit(s_type(mb, 9, 0, 3'b010));
    add_store(mb, 4'hF, link_pc + 8);
    mb += 4;
    end_test("jumps");
    emit(s_type(mb, 1, 0, 3'b010));
    add_store(mb, 4'hF, a);
    end_test("halt");
    emit(i_type(1, 0, 3'b000, 0, opc_system));
    emit(s_type(mb + 4, 1, 0, 3'b010));
  endtask

  // ------------------------------
  // Store scoreboard
  // ------------------------------
  assign cur_addr = exp_addr[store_idx[6:0]];
  assign cur_strb = exp_strb[store_idx[6:0]];
  assign cur_data = exp_data[store_idx[6:0]];

  always @(posedge clk) begin
    if (!rst_n) begin
      store_idx <= 0;
    end else if (dmem_we) begin
      store_idx <= store_idx + 1;
    end
  end

  store_in_table: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we |-> (store_idx < n_exp))
    else begin
      errors++;
      $display("Unexpected extra store to address %h", $sampled(dmem_waddr));
    end

  store_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (dmem_we && (store_idx < n_exp)) |-> (dmem_waddr == cur_addr))
    else begin
      errors++;
      $display("CHECK FAILED dmem_waddr expected %h got %h",
               $sampled(cur_addr), $sampled(dmem_waddr));
    end

  store_strb: assert property (@(posedge clk) disable iff (!rst_n)
    (dmem_we && (store_idx < n_exp)) |-> (dmem_wstrb == cur_strb))
    else begin
      errors++;
      $display("CHECK FAILED dmem_wstrb expected %h got %h",
               $sampled(cur_strb), $sampled(dmem_wstrb));
    end

  store_data: assert property (@(posedge clk) disable iff (!rst_n)
    (dmem_we && (store_idx < n_exp)) |-> (dmem_wdata == cur_data))
    else begin
      errors++;
      $display("CHECK FAILED dmem_wdata expected %h got %h",
               $sampled(cur_data), $sampled(dmem_wdata));
    end

  // One line per test once its last store has landed
  always @(negedge clk) begin
    if (rst_n && (test_idx < n_tests) && (store_idx > test_last[test_idx[2:0]])) begin
      if (errors == err_mark) begin
        tests_pass++;
        $display("PASS  %s", test_name[test_idx[2:0]]);
      end else begin
        tests_fail++;
        $display("FAIL  %s, %0d failed checks", test_name[test_idx[2:0]], errors - err_mark);
      end
      err_mark = errors;
      test_idx++;
    end
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int cycles;
    clk   = 1'b0;
    rst_n = 1'b0;
    a     = 32'h8765_4321;
    b     = 32'hFFFF_FF85;
    // Spare ROM words are NOPs carrying their word index
    for (int i = 0; i < 256; i++) begin
      irom[i[7:0]] = i_type(i, 0, 3'b000, 0, opc_op_imm);
      dram[i[7:0]] = {16'hDA7A, 8'(i), ~8'(i)};
    end
    build_program();
    repeat (2) @(negedge clk);
    rst_n  = 1'b1;
    cycles = 0;
    while (!ebreak && (cycles < 2000)) begin
      @(negedge clk);
      cycles++;
    end
    if (!ebreak) begin
      $display("Timeout: the core never halted within 2000 cycles");
      $display("Simulation failed");
    end else begin
      // A halted core stays silent
      repeat (8) @(negedge clk);
      if (store_idx != n_exp) begin
        errors++;
        $display("Saw %0d stores but the program should make %0d", store_idx, n_exp);
      end
      $display("Tests passed: %0d, failed: %0d", tests_pass, tests_fail);
      if ((errors == 0) && (tests_fail == 0)) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
    end
    $finish;
  end

endmodule

// File: rv_core_properties.sv
`timescale 1ns/1ps

module rv_core_properties import rv_core_pkg::*; (
  input logic            clk,
  input logic            rst_n,
  input logic            imem_ren,
  input logic [xlen-1:0] imem_raddr,
  input logic [31:0]     imem_rdata,
  input logic            dmem_ren,
  input logic            dmem_we,
  input logic [3:0]      dmem_wstrb,
  input logic            ebreak
);

  // ------------------------------
  // Memory ports
  // ------------------------------
  ren_we_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_ren && dmem_we))
    else $error("dmem_ren and dmem_we are high in the same cycle");

  legal_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we |-> (dmem_wstrb inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                    4'b0011, 4'b1100, 4'b1111}))
    else $error("dmem_wstrb %h is not a legal byte, half or word strobe", $sampled(dmem_wstrb));

  fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    imem_raddr[1:0] == 2'b00)
    else $error("imem_raddr %h is not word aligned", $sampled(imem_raddr));

  // First fetch after reset
  reset_fetch: assert property (@(posedge clk)
    $rose(rst_n) |-> (imem_ren && (imem_raddr == reset_pc)))
    else $error("First fetch after reset is not at the reset address");

  // ------------------------------
  // Halt behaviour
  // ------------------------------
  ebreak_next_edge: assert property (@(posedge clk) disable iff (!rst_n)
    (imem_ren && (imem_rdata == instr_ebreak)) |-> !ebreak ##1 ebreak)
    else $error("ebreak did not rise on the edge after the EBREAK fetch");

  halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    ebreak |=> ebreak)
    else $error("ebreak dropped before reset");

  halt_pc_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ebreak |=> $stable(imem_raddr))
    else $error("imem_raddr moved while halted");

  halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    ebreak |-> (!imem_ren && !dmem_ren && !dmem_we))
    else $error("Memory enable active while halted");

endmodule

bind rv_core rv_core_properties u_rv_core_properties (
  .clk        (clk),
  .rst_n      (rst_n),
  .imem_ren   (imem_ren),
  .imem_raddr (imem_raddr),
  .imem_rdata (imem_rdata),
  .dmem_ren   (dmem_ren),
  .dmem_we    (dmem_we),
  .dmem_wstrb (dmem_wstrb),
  .ebreak     (ebreak)
);

// File: rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  output logic            imem_ren,
  output logic [xlen-1:0] imem_raddr,
  input  logic [31:0]     imem_rdata,
  output logic            dmem_ren,
  output logic [xlen-1:0] dmem_raddr,
  input  logic [xlen-1:0] dmem_rdata,
  output logic            dmem_we,
  output logic [xlen-1:0] dmem_waddr,
  output logic [xlen-1:0] dmem_wdata,
  output logic [3:0]      dmem_wstrb,
  output logic            ebreak
);

  ctrl_t           ctrl;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_plus4;
  logic            halted;
  logic            redirect;
  logic [xlen-1:0] redirect_target;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] wb_data;

  // ------------------------------
  // Datapath
  // ------------------------------
  rv_fetch u_fetch (
    .clk             (clk),
    .rst_n           (rst_n),
    .is_ebreak       (ctrl.is_ebreak),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .pc              (pc),
    .pc_plus4        (pc_plus4),
    .halted          (halted)
  );

  rv_decoder u_decoder (
    .instr (imem_rdata),
    .ctrl  (ctrl)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rd       (ctrl.rd),
    .we       (ctrl.reg_write && !halted),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute u_execute (
    .ctrl            (ctrl),
    .pc              (pc),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .alu_result      (alu_result),
    .redirect        (redirect),
    .redirect_target (redirect_target)
  );

  rv_lsu u_lsu (
    .ctrl       (ctrl),
    .halted     (halted),
    .addr       (alu_result),
    .store_data (rs2_data),
    .dmem_ren   (dmem_ren),
    .dmem_we    (dmem_we),
    .dmem_raddr (dmem_raddr),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_rdata (dmem_rdata),
    .load_data  (load_data)
  );

  // Write-back select
  always_comb begin
    case (ctrl.wb_src)
      wb_mem:      wb_data = load_data;
      wb_pc_plus4: wb_data = pc_plus4;
      default:     wb_data = alu_result;
    endcase
  end

  assign imem_ren   = !halted;
  assign imem_raddr = pc;
  assign ebreak     = halted;

endmodule

// File: rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu import rv_core_pkg::*; (
  input  ctrl_t           ctrl,
  input  logic            halted,
  input  logic [xlen-1:0] addr,
  input  logic [xlen-1:0] store_data,
  output logic            dmem_ren,
  output logic            dmem_we,
  output logic [xlen-1:0] dmem_raddr,
  output logic [xlen-1:0] dmem_waddr,
  output logic [xlen-1:0] dmem_wdata,
  output logic [3:0]      dmem_wstrb,
  input  logic [xlen-1:0] dmem_rdata,
  output logic [xlen-1:0] load_data
);

  logic [xlen-1:0] word_addr;
  logic [1:0]      lane;
  logic [7:0]      rd_byte;
  logic [15:0]     rd_half;

  assign word_addr = {addr[xlen-1:2], 2'b00};
  assign lane      = addr[1:0];

  // No memory traffic once halted
  assign dmem_ren   = ctrl.mem_read && !halted;
  assign dmem_we    = ctrl.mem_write && !halted;
  assign dmem_raddr = word_addr;
  assign dmem_waddr = word_addr;

  // ------------------------------
  // Store lanes
  // ------------------------------
  always_comb begin
    case (ctrl.mem_size)
      size_byte: begin
        dmem_wdata = {4{store_data[7:0]}};
        dmem_wstrb = 4'b0001 << lane;
      end
      size_half: begin
        dmem_wdata = {2{store_data[15:0]}};
        dmem_wstrb = lane[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata = store_data;
        dmem_wstrb = 4'b1111;
      end
    endcase
  end

  // ------------------------------
  // Load extraction
  // ------------------------------
  assign rd_byte = dmem_rdata[8*lane +: 8];
  assign rd_half = lane[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

  always_comb begin
    case (ctrl.mem_size)
      size_byte: load_data = {{24{rd_byte[7] && !ctrl.mem_unsigned}}, rd_byte};
      size_half: load_data = {{16{rd_half[15] && !ctrl.mem_unsigned}}, rd_half};
      default:   load_data = dmem_rdata;
    endcase
  end

endmodule

// File: rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_core_pkg::*; (
  input  ctrl_t           ctrl,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  output logic [xlen-1:0] alu_result,
  output logic            redirect,
  output logic [xlen-1:0] redirect_target
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic            taken;
  logic [xlen-1:0] pc_target;

  // ------------------------------
  // ALU
  // ------------------------------
  assign op_a  = ctrl.alu_a_pc ? pc : rs1_data;
  assign op_b  = ctrl.alu_b_imm ? ctrl.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_sll:    alu_result = op_a << shamt;
      alu_slt:    alu_result = xlen'($signed(op_a) < $signed(op_b));
      alu_sltu:   alu_result = xlen'(op_a < op_b);
      alu_xor:    alu_result = op_a ^ op_b;
      alu_srl:    alu_result = op_a >> shamt;
      alu_sra:    alu_result = $unsigned($signed(op_a) >>> shamt);
      alu_or:     alu_result = op_a | op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_pass_b: alu_result = op_b;
      default:    alu_result = op_a + op_b;
    endcase
  end

  // ------------------------------
  // Branch condition
  // ------------------------------
  always_comb begin
    case (ctrl.funct3)
      f3_beq:  taken = (rs1_data == rs2_data);
      f3_bne:  taken = (rs1_data != rs2_data);
      f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      f3_bltu: taken = (rs1_data < rs2_data);
      f3_bgeu: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  // Branches and JAL are PC relative
  assign pc_target = pc + ctrl.imm;

  // JALR takes rs1 + imm from the ALU, bit 0 cleared
  assign redirect_target = ctrl.is_jalr ? {alu_result[xlen-1:1], 1'b0} : pc_target;

  assign redirect = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && taken);

endmodule

// File: rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  input  logic [reg_addr_w-1:0] rd,
  input  logic                  we,
  input  logic [xlen-1:0]       wdata,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data
);

  localparam int nregs = 2 ** reg_addr_w;

  // x0 has no storage
  logic [xlen-1:0] regs [1:nregs-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // Reads see the value written at the previous edge
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder import rv_core_pkg::*; (
  input  logic [31:0] instr,
  output ctrl_t       ctrl
);

  logic        legal;
  logic [2:0]  raw_f3;
  logic [6:0]  raw_f7;
  logic [31:0] dec;
  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  alu_op_e     alu_fn;

  assign raw_f3 = instr[14:12];
  assign raw_f7 = instr[31:25];

  // ------------------------------
  // Legality check
  // ------------------------------
  always_comb begin
    legal = 1'b0;
    case (opcode_e'(instr[6:0]))
      opc_op: begin
        legal = (raw_f7 == 7'h00) ||
                ((raw_f7 == 7'h20) && ((raw_f3 == 3'b000) || (raw_f3 == 3'b101)));
      end
      opc_op_imm: begin
        if (raw_f3 == 3'b001) begin
          legal = (raw_f7 == 7'h00);
        end else if (raw_f3 == 3'b101) begin
          legal = (raw_f7 == 7'h00) || (raw_f7 == 7'h20);
        end else begin
          legal = 1'b1;
        end
      end
      opc_lui, opc_auipc, opc_jal: legal = 1'b1;
      opc_jalr:     legal = (raw_f3 == 3'b000);
      opc_branch:   legal = (raw_f3[2:1] != 2'b01);
      opc_load:     legal = (raw_f3[1:0] != 2'b11) && (raw_f3[2:1] != 2'b11);
      opc_store:    legal = !raw_f3[2] && (raw_f3[1:0] != 2'b11);
      // Only EBREAK acts; ECALL and CSR accesses fall back to a NOP
      opc_system:   legal = (instr == instr_ebreak);
      // FENCE and unknown opcodes fall back to a NOP
      default:      legal = 1'b0;
    endcase
  end

  assign dec    = legal ? instr : instr_nop;
  assign opcode = opcode_e'(dec[6:0]);
  assign funct3 = dec[14:12];
  assign funct7 = dec[31:25];

  // Immediates
  assign imm_i = {{20{dec[31]}}, dec[31:20]};
  assign imm_s = {{20{dec[31]}}, dec[31:25], dec[11:7]};
  assign imm_b = {{19{dec[31]}}, dec[31], dec[7], dec[30:25], dec[11:8], 1'b0};
  assign imm_u = {dec[31:12], 12'h000};
  assign imm_j = {{11{dec[31]}}, dec[31], dec[19:12], dec[20], dec[30:21], 1'b0};

  // ALU function for OP and OP-IMM
  // SUB only exists in the register form
  always_comb begin
    case (funct3)
      3'b000:  alu_fn = ((opcode == opc_op) && funct7[5]) ? alu_sub : alu_add;
      3'b001:  alu_fn = alu_sll;
      3'b010:  alu_fn = alu_slt;
      3'b011:  alu_fn = alu_sltu;
      3'b100:  alu_fn = alu_xor;
      3'b101:  alu_fn = funct7[5] ? alu_sra : alu_srl;
      3'b110:  alu_fn = alu_or;
      default: alu_fn = alu_and;
    endcase
  end

  // ------------------------------
  // Control assembly
  // ------------------------------
  always_comb begin
    ctrl              = '0;
    ctrl.alu_op       = alu_add;
    ctrl.wb_src       = wb_alu;
    ctrl.mem_size     = mem_size_e'(funct3[1:0]);
    ctrl.mem_unsigned = funct3[2];
    ctrl.funct3       = funct3;
    ctrl.rd           = dec[11:7];
    ctrl.rs1          = dec[19:15];
    ctrl.rs2          = dec[24:20];
    ctrl.imm          = imm_i;
    case (opcode)
      opc_op: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_fn;
      end
      opc_op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.alu_op    = alu_fn;
      end
      opc_lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.alu_op    = alu_pass_b;
        ctrl.imm       = imm_u;
      end
      opc_auipc: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_a_pc  = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.imm       = imm_u;
      end
      opc_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jal    = 1'b1;
        ctrl.wb_src    = wb_pc_plus4;
        ctrl.imm       = imm_j;
      end
      opc_jalr: begin
        // ALU forms rs1 + imm as the jump target
        ctrl.reg_write = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.wb_src    = wb_pc_plus4;
      end
      opc_branch: begin
        ctrl.is_branch = 1'b1;
        ctrl.imm       = imm_b;
      end
      opc_load: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.wb_src    = wb_mem;
      end
      opc_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.imm       = imm_s;
      end
      opc_system: ctrl.is_ebreak = 1'b1;
      default: ;
    endcase
    // x0 is never written
    if (ctrl.rd == '0) begin
      ctrl.reg_write = 1'b0;
    end
  end

endmodule

// File: rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch import rv_core_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            is_ebreak,
  input  logic            redirect,
  input  logic [xlen-1:0] redirect_target,
  output logic [xlen-1:0] pc,
  output logic [xlen-1:0] pc_plus4,
  output logic            halted
);

  logic [xlen-1:0] pc_next;

  assign pc_plus4 = pc + xlen'(4);

  // Jumps and taken branches override the sequential path
  assign pc_next = redirect ? redirect_target : pc_plus4;

  // ------------------------------
  // PC register and halt latch
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= reset_pc;
      halted <= 1'b0;
    end else if (!halted) begin
      if (is_ebreak) begin
        // PC stays on the EBREAK from here on
        halted <= 1'b1;
      end else begin
        pc <= pc_next;
      end
    end
  end

endmodule

// File: rv_core_pkg.sv
package rv_core_pkg;

  // ------------------------------
  // Architectural constants
  // ------------------------------
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc     = '0;
  localparam logic [31:0]     instr_nop    = 32'h0000_0013;
  localparam logic [31:0]     instr_ebreak = 32'h0010_0073;

  // Branch conditions, as carried in funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [6:0] {
    opc_load     = 7'b0000011,
    opc_misc_mem = 7'b0001111,
    opc_op_imm   = 7'b0010011,
    opc_auipc    = 7'b0010111,
    opc_store    = 7'b0100011,
    opc_op       = 7'b0110011,
    opc_lui      = 7'b0110111,
    opc_branch   = 7'b1100011,
    opc_jalr     = 7'b1100111,
    opc_jal      = 7'b1101111,
    opc_system   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_pc_plus4
  } wb_src_e;

  // Matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

  // Decoded control of one instruction
  typedef struct packed {
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_ebreak;
    logic                  alu_a_pc;
    logic                  alu_b_imm;
    alu_op_e               alu_op;
    wb_src_e               wb_src;
    mem_size_e             mem_size;
    logic                  mem_unsigned;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
  } ctrl_t;

endpackage
